//--- verilog/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath widths
`define ISA_WIDTH            32           // data word and address width
`define REG_FILE_ADDR_WIDTH  5            // register index, 32 registers

// hazard command encoding width, the enum itself lives in cpu_pkg
`define HAZD_CTL_WIDTH       2

// user input hardware
`define SWITCH_CNT           16           // number of toggle switches

// data memory and the memory mapped input region
`define DMEM_DEPTH           256          // words in the data memory
`define IO_BASE              32'hFFFF_FC00 // first word address of the input region
`define SWITCH_ADDR          32'hFFFF_FC70 // reads the switches, rest of region reads keypad

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    // next state request from the hazard unit for the wb stage
    typedef enum logic [`HAZD_CTL_WIDTH - 1:0] {
        HAZD_CTL_NORMAL = 2'd0,                        // capture new item
        HAZD_CTL_NO_OP  = 2'd1,                        // insert a bubble
        HAZD_CTL_RETRY  = 2'd2                         // replay the held item
    } hazd_ctl_e;

    // item arriving from the ex/mem stage register
    typedef struct packed {
        logic                                no_op;            // mem stage stopped
        logic                                reg_write_enable; // item writes a register
        logic                                mem_read_enable;  // item is a load
        logic                                mem_write_enable; // item is a store
        logic [`ISA_WIDTH - 1:0]             alu_result;       // also the memory address
        logic [`ISA_WIDTH - 1:0]             store_data;       // word to store
        logic [`REG_FILE_ADDR_WIDTH - 1:0]   dest_reg_idx;     // destination register
    } mem_stage_t;

    // item held by the mem/wb stage register
    // also the forwarding source for the ex stage
    typedef struct packed {
        logic                                no_op;            // suppresses write back
        logic                                reg_write_enable; // item writes a register
        logic                                mem_read_enable;  // select loaded data
        logic [`ISA_WIDTH - 1:0]             alu_result;       // alu path result
        logic [`ISA_WIDTH - 1:0]             mem_read_data;    // memory or user input word
        logic [`REG_FILE_ADDR_WIDTH - 1:0]   dest_reg_idx;     // destination register
    } wb_stage_t;

endpackage

//--- verilog/data_mem.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

// memory stage storage
// word addressed, write on the clock edge, read straight through
module data_mem (
    input  logic                       clk,
    input  logic                       rst_n,           // only qualifies the assertion

    input  cpu_pkg::mem_stage_t        mem_in,          // item from ex/mem register

    output logic [`ISA_WIDTH - 1:0]    mem_read_data,   // to mem_wb_reg
    output logic                       input_enable     // address falls in the input region
);

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);       // index bits into the array

    logic [`ISA_WIDTH - 1:0] mem_array [0:`DMEM_DEPTH - 1]; // storage, no reset
    logic [DMEM_AW - 1:0]    word_idx;                  // low address bits
    logic                    store_live;                // store that really lands

    assign word_idx = mem_in.alu_result[DMEM_AW - 1:0]; // aliasing above depth is fine

    // everything from IO_BASE up belongs to user input
    assign input_enable = (mem_in.alu_result >= `IO_BASE);

    // stores into the input region have nowhere to go
    assign store_live = mem_in.mem_write_enable
                      & ~mem_in.no_op
                      & ~input_enable;

    always_ff @(posedge clk) begin
        if (store_live) begin
            mem_array[word_idx] <= mem_in.store_data;   // visible next cycle
        end
    end

    // asynchronous read, the stage register picks memory vs input later
    assign mem_read_data = mem_array[word_idx];

    // a live item is either a load or a store, never both at once
    // the ex stage decode guarantees this, mem stage relies on it
    a_no_load_store: assert property (
        @(posedge clk) disable iff (!rst_n)
        !mem_in.no_op |-> !(mem_in.mem_read_enable && mem_in.mem_write_enable)
    ) else $error("data_mem: live item with both read and write enabled");

endmodule

//--- verilog/input_unit.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

// user input side of the memory stage
// keeps the last keypad word and decodes the switch address
module input_unit (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [`ISA_WIDTH - 1:0]    keypad_data,     // raw keypad word from hardware
    input  logic                       keypad_strobe,   // keypad has a new entry
    input  logic [`ISA_WIDTH - 1:0]    address,         // alu_result of the mem item

    output logic [`ISA_WIDTH - 1:0]    keypad_value,    // latched keypad word
    output logic                       switch_enable    // io read targets the switches
);

    logic [`ISA_WIDTH - 1:0] keypad_latch;              // last strobed entry

    // hold the keypad entry until the next strobe
    // a load can then see it long after the key was pressed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            keypad_latch <= '0;                         // no entry yet
        end else if (keypad_strobe) begin
            keypad_latch <= keypad_data;                // shows one edge after strobe
        end
    end

    assign keypad_value = keypad_latch;

    // only one address in the region maps to the switches
    // only meaningful together with input_enable from data_mem
    assign switch_enable = (address == `SWITCH_ADDR);

endmodule

//--- verilog/mem_wb_reg.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

// stage register between the memory stage and the write back stage
// hazard_control chooses capture, bubble or replay each cycle
module mem_wb_reg (
    input  logic                       clk,
    input  logic                       rst_n,

    input  cpu_pkg::hazd_ctl_e         hazard_control,  // next state for the wb stage
    input  logic                       ignore_no_op,    // let a stopped mem item through

    input  cpu_pkg::mem_stage_t        mem_in,          // item from ex/mem register
    input  logic [`ISA_WIDTH - 1:0]    mem_read_data,   // from data_mem
    input  logic                       input_enable,    // from data_mem, io region hit
    input  logic                       switch_enable,   // from input_unit, switch address
    input  logic [`ISA_WIDTH - 1:0]    keypad_value,    // from input_unit
    input  logic [`SWITCH_CNT - 1:0]   switch_map,      // toggle switches, straight from pins

    output cpu_pkg::wb_stage_t         wb_out           // to general_reg and forwarding
);

    logic [`ISA_WIDTH - 1:0] load_word;                 // word a load would capture

    // io loads bypass memory, switches zero extended to a full word
    always_comb begin
        if (input_enable && switch_enable) begin
            load_word = {{(`ISA_WIDTH - `SWITCH_CNT){1'b0}}, switch_map};
        end else if (input_enable) begin
            load_word = keypad_value;
        end else begin
            load_word = mem_read_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_out <= '0;                               // no_op and write enable both low
        end else if (mem_in.no_op && !ignore_no_op) begin
            wb_out.no_op <= 1'b1;                       // mem stage stopped, hold the rest
        end else begin
            case (hazard_control)
                cpu_pkg::HAZD_CTL_NO_OP: begin
                    wb_out.no_op <= 1'b1;               // bubble, fields held
                end
                cpu_pkg::HAZD_CTL_RETRY: begin
                    wb_out.no_op <= 1'b0;               // replay held fields
                end
                default: begin                          // normal capture
                    wb_out.no_op            <= 1'b0;
                    wb_out.reg_write_enable <= mem_in.reg_write_enable;
                    wb_out.mem_read_enable  <= mem_in.mem_read_enable;
                    wb_out.alu_result       <= mem_in.alu_result;
                    wb_out.mem_read_data    <= load_word;
                    wb_out.dest_reg_idx     <= mem_in.dest_reg_idx;
                end
            endcase
        end
    end

    // an unknown command would silently fall into capture
    a_hazd_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(hazard_control)
    ) else $error("mem_wb_reg: hazard_control unknown");

endmodule

//--- verilog/general_reg.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

// general register file, write back side of the pipe
// one write port fed by the wb stage, two combinational read ports
module general_reg (
    input  logic                                clk,
    input  logic                                rst_n,

    input  cpu_pkg::wb_stage_t                  wb_in,       // from mem_wb_reg

    input  logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_a,  // first read index
    input  logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_b,  // second read index
    output logic [`ISA_WIDTH - 1:0]             read_data_a, // value of read_idx_a
    output logic [`ISA_WIDTH - 1:0]             read_data_b  // value of read_idx_b
);

    localparam int REG_CNT = 2 ** `REG_FILE_ADDR_WIDTH;       // 32 registers

    logic [`ISA_WIDTH - 1:0] regs [0:REG_CNT - 1];            // register storage
    logic [`ISA_WIDTH - 1:0] write_data;                      // selected wb value
    logic                    write_live;                      // write really happens

    // loads write back memory data, everything else the alu result
    assign write_data = wb_in.mem_read_enable ? wb_in.mem_read_data
                                              : wb_in.alu_result;

    // bubbles and the zero register never change state
    assign write_live = wb_in.reg_write_enable
                      & ~wb_in.no_op
                      & (wb_in.dest_reg_idx != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0;                                // clean file after reset
            end
        end else if (write_live) begin
            regs[wb_in.dest_reg_idx] <= write_data;           // seen from next cycle
        end
    end

    // register 0 is hardwired, no bypass from the write port
    assign read_data_a = (read_idx_a == '0) ? '0 : regs[read_idx_a];
    assign read_data_b = (read_idx_b == '0) ? '0 : regs[read_idx_b];

    // a write aimed at register 0 must not leave a trace
    a_r0_never_written: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_in.reg_write_enable && !wb_in.no_op && wb_in.dest_reg_idx == '0)
        |=> (regs[0] == '0)
    ) else $error("general_reg: register 0 was written");

endmodule

//--- verilog/mem_wb_top.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

// back end of the pipe
// memory stage, mem/wb stage register and register file write back
module mem_wb_top (
    input  logic                                clk,
    input  logic                                rst_n,

    input  cpu_pkg::mem_stage_t                 mem_in,         // item from ex/mem register
    input  cpu_pkg::hazd_ctl_e                  hazard_control, // from hazard unit
    input  logic                                ignore_no_op,   // from hazard unit

    input  logic [`ISA_WIDTH - 1:0]             keypad_data,    // keypad hardware
    input  logic                                keypad_strobe,  // keypad new entry
    input  logic [`SWITCH_CNT - 1:0]            switch_map,     // toggle switches

    output cpu_pkg::wb_stage_t                  wb_out,         // wb item, forwarding source

    input  logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_a,     // observation port a
    input  logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_b,     // observation port b
    output logic [`ISA_WIDTH - 1:0]             read_data_a,
    output logic [`ISA_WIDTH - 1:0]             read_data_b
);

    logic [`ISA_WIDTH - 1:0] mem_read_data;                     // data_mem to stage reg
    logic                    input_enable;                      // io region hit
    logic                    switch_enable;                     // switch address hit
    logic [`ISA_WIDTH - 1:0] keypad_value;                      // latched keypad word

    data_mem data_mem_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_in        (mem_in),
        .mem_read_data (mem_read_data),
        .input_enable  (input_enable)
    );

    input_unit input_unit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .keypad_data   (keypad_data),
        .keypad_strobe (keypad_strobe),
        .address       (mem_in.alu_result),                     // same address as memory
        .keypad_value  (keypad_value),
        .switch_enable (switch_enable)
    );

    mem_wb_reg mem_wb_reg_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .hazard_control (hazard_control),
        .ignore_no_op   (ignore_no_op),
        .mem_in         (mem_in),
        .mem_read_data  (mem_read_data),
        .input_enable   (input_enable),
        .switch_enable  (switch_enable),
        .keypad_value   (keypad_value),
        .switch_map     (switch_map),
        .wb_out         (wb_out)
    );

    general_reg general_reg_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_in       (wb_out),
        .read_idx_a  (read_idx_a),
        .read_idx_b  (read_idx_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b)
    );

endmodule

//--- verif/mem_wb_tb.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module mem_wb_tb;

    typedef struct packed {
        cpu_pkg::mem_stage_t                 mem_in;         // item entering the mem stage
        cpu_pkg::hazd_ctl_e                  hazard;         // command for the stage register
        logic                                ignore_no_op;
        logic [`ISA_WIDTH - 1:0]             keypad_data;
        logic                                keypad_strobe;
        logic [`SWITCH_CNT - 1:0]            switch_map;
        logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_a;     // observed register on port a
        logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_b;     // observed register on port b
    } row_t;

    logic                                clk;
    logic                                rst_n;
    cpu_pkg::mem_stage_t                 mem_in;
    cpu_pkg::hazd_ctl_e                  hazard_control;
    logic                                ignore_no_op;
    logic [`ISA_WIDTH - 1:0]             keypad_data;
    logic                                keypad_strobe;
    logic [`SWITCH_CNT - 1:0]            switch_map;
    cpu_pkg::wb_stage_t                  wb_out;
    logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_a;
    logic [`REG_FILE_ADDR_WIDTH - 1:0]   read_idx_b;
    logic [`ISA_WIDTH - 1:0]             read_data_a;
    logic [`ISA_WIDTH - 1:0]             read_data_b;

    row_t                    row_q [$];                      // stimulus table
    string                   name_q [$];                     // test name per row
    logic [`ISA_WIDTH - 1:0] data_word [0:11];               // lfsr data for the table
    logic [31:0]             lfsr_state;
    int                      cycle_cnt = 0;
    int                      cycle_limit = 0;                // set once the table is built

    logic [`ISA_WIDTH - 1:0] model_mem [0:`DMEM_DEPTH - 1];  // reference data memory
    logic [`ISA_WIDTH - 1:0] model_regs [0:31];              // reference register file
    logic [`ISA_WIDTH - 1:0] model_keypad;                   // reference keypad latch
    cpu_pkg::wb_stage_t      exp_wb;                         // expected stage register

    mem_wb_top mem_wb_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_in         (mem_in),
        .hazard_control (hazard_control),
        .ignore_no_op   (ignore_no_op),
        .keypad_data    (keypad_data),
        .keypad_strobe  (keypad_strobe),
        .switch_map     (switch_map),
        .wb_out         (wb_out),
        .read_idx_a     (read_idx_a),
        .read_idx_b     (read_idx_b),
        .read_data_a    (read_data_a),
        .read_data_b    (read_data_b)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                               // 4 ns period
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the table did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "run ended by the cycle limit");
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output logic [`ISA_WIDTH - 1:0] w);
        w = '0;
        for (int b = 0; b < `ISA_WIDTH; b++) begin
            lfsr_state = lfsr_next(lfsr_state);              // one step per bit
            w = {w[`ISA_WIDTH - 2:0], lfsr_state[31]};
        end
    endtask

    // random alu value that is also a written, non io address
    function automatic logic [31:0] safe_alu(input logic [31:0] w, input logic [7:0] idx);
        return {1'b0, w[30:8], idx};
    endfunction

    function automatic cpu_pkg::mem_stage_t make_item(input logic no_op, input logic we,
            input logic re, input logic wr, input logic [31:0] addr,
            input logic [31:0] sdata, input logic [4:0] dest);
        cpu_pkg::mem_stage_t m;
        m.no_op            = no_op;
        m.reg_write_enable = we;
        m.mem_read_enable  = re;
        m.mem_write_enable = wr;
        m.alu_result       = addr;
        m.store_data       = sdata;
        m.dest_reg_idx     = dest;
        return m;
    endfunction

    task automatic add_row(input string name, input cpu_pkg::mem_stage_t item,
            input cpu_pkg::hazd_ctl_e hz, input logic ign, input logic [31:0] kd,
            input logic ks, input logic [15:0] sw, input logic [4:0] ra, input logic [4:0] rb);
        row_t r;
        r.mem_in        = item;
        r.hazard        = hz;
        r.ignore_no_op  = ign;
        r.keypad_data   = kd;
        r.keypad_strobe = ks;
        r.switch_map    = sw;
        r.read_idx_a    = ra;
        r.read_idx_b    = rb;
        row_q.push_back(r);
        name_q.push_back(name);
    endtask

    task automatic build_table();
        logic [`SWITCH_CNT - 1:0]  sw;
        cpu_pkg::mem_stage_t       idle;
        for (int k = 0; k < 12; k++) begin
            draw_word(data_word[k]);
        end
        sw   = data_word[4][`SWITCH_CNT - 1:0];
        idle = make_item(0, 0, 0, 0, 32'h10, 32'h0, 5'd0);   // harmless filler item
        add_row("reset_then_store", make_item(0, 0, 0, 1, 32'h10, data_word[0], 5'd0),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, 16'h0, 5'd3, 5'd5);
        add_row("store_b", make_item(0, 0, 0, 1, 32'h24, data_word[1], 5'd0),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, 16'h0, 5'd3, 5'd6);
        add_row("load_a", make_item(0, 1, 1, 0, 32'h10, 32'h0, 5'd3),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, 16'h0, 5'd3, 5'd0);
        add_row("alu_to_r5", make_item(0, 1, 0, 0, safe_alu(data_word[2], 8'h24), 32'h0, 5'd5),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, 16'h0, 5'd3, 5'd5);
        add_row("load_b", make_item(0, 1, 1, 0, 32'h24, 32'h0, 5'd6),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, 16'h0, 5'd3, 5'd5);
        add_row("keypad_strobe", make_item(0, 1, 0, 0, safe_alu(data_word[5], 8'h10), 32'h0, 5'd7),
                cpu_pkg::HAZD_CTL_NORMAL, 0, data_word[3], 1, sw, 5'd5, 5'd6);
        add_row("io_keypad_load", make_item(0, 1, 1, 0, `IO_BASE + 32'h4, 32'h0, 5'd8),
                cpu_pkg::HAZD_CTL_NORMAL, 0, data_word[6], 0, sw, 5'd6, 5'd7);
        add_row("io_switch_load", make_item(0, 1, 1, 0, `SWITCH_ADDR, 32'h0, 5'd9),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd7, 5'd8);
        add_row("io_store", make_item(0, 0, 0, 1, `IO_BASE + 32'h10, data_word[7], 5'd0),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd8, 5'd9);
        add_row("reload_a", make_item(0, 1, 1, 0, 32'h10, 32'h0, 5'd10),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd8, 5'd9);
        add_row("hazard_no_op", make_item(0, 1, 0, 0, safe_alu(data_word[8], 8'h24), 32'h0, 5'd11),
                cpu_pkg::HAZD_CTL_NO_OP, 0, 32'h0, 0, sw, 5'd9, 5'd10);
        add_row("mem_no_op", make_item(1, 1, 0, 0, safe_alu(data_word[9], 8'h10), 32'h0, 5'd12),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd10, 5'd11);
        add_row("ignore_no_op", make_item(1, 1, 0, 0, safe_alu(data_word[9], 8'h10), 32'h0, 5'd12),
                cpu_pkg::HAZD_CTL_NORMAL, 1, 32'h0, 0, sw, 5'd10, 5'd12);
        add_row("retry_setup", make_item(0, 1, 0, 0, safe_alu(data_word[10], 8'h24), 32'h0, 5'd13),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd11, 5'd12);
        add_row("retry", make_item(0, 1, 0, 0, safe_alu(data_word[11], 8'h10), 32'h0, 5'd14),
                cpu_pkg::HAZD_CTL_RETRY, 0, 32'h0, 0, sw, 5'd12, 5'd13);
        add_row("retry_again", make_item(0, 1, 0, 0, safe_alu(data_word[11], 8'h10), 32'h0, 5'd14),
                cpu_pkg::HAZD_CTL_RETRY, 0, 32'h0, 0, sw, 5'd13, 5'd14);
        add_row("r0_write", make_item(0, 1, 0, 0, safe_alu(data_word[11], 8'h24), 32'h0, 5'd0),
                cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd13, 5'd14);
        add_row("observe_r0", idle, cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd0, 5'd13);
        add_row("observe_r0_b", idle, cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd0, 5'd14);
        add_row("observe_loads", idle, cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd3, 5'd6);
        add_row("observe_io", idle, cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd8, 5'd9);
        add_row("observe_hold", idle, cpu_pkg::HAZD_CTL_NORMAL, 0, 32'h0, 0, sw, 5'd10, 5'd11);
    endtask

    task automatic apply_row(input row_t r);
        mem_in         = r.mem_in;
        hazard_control = r.hazard;
        ignore_no_op   = r.ignore_no_op;
        keypad_data    = r.keypad_data;
        keypad_strobe  = r.keypad_strobe;
        switch_map     = r.switch_map;
        read_idx_a     = r.read_idx_a;
        read_idx_b     = r.read_idx_b;
    endtask

    task automatic check_value(input string test_name, input string what,
            input logic [95:0] expected, input logic [95:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // next edge of the reference model, state read before any of it moves
    task automatic update_model(input row_t r);
        logic [`ISA_WIDTH - 1:0] addr;
        logic [`ISA_WIDTH - 1:0] load_word;
        addr = r.mem_in.alu_result;
        if (exp_wb.reg_write_enable && !exp_wb.no_op && exp_wb.dest_reg_idx != 0) begin
            model_regs[exp_wb.dest_reg_idx] = exp_wb.mem_read_enable ? exp_wb.mem_read_data
                                                                     : exp_wb.alu_result;
        end
        if (addr >= `IO_BASE) begin
            load_word = (addr == `SWITCH_ADDR) ? `ISA_WIDTH'(r.switch_map) : model_keypad;
        end else begin
            load_word = model_mem[addr % `DMEM_DEPTH];
        end
        if (r.mem_in.no_op && !r.ignore_no_op) begin
            exp_wb.no_op = 1'b1;                             // stopped mem stage, hold
        end else if (r.hazard == cpu_pkg::HAZD_CTL_NO_OP) begin
            exp_wb.no_op = 1'b1;
        end else if (r.hazard == cpu_pkg::HAZD_CTL_RETRY) begin
            exp_wb.no_op = 1'b0;
        end else begin
            exp_wb.no_op            = 1'b0;
            exp_wb.reg_write_enable = r.mem_in.reg_write_enable;
            exp_wb.mem_read_enable  = r.mem_in.mem_read_enable;
            exp_wb.alu_result       = addr;
            exp_wb.mem_read_data    = load_word;
            exp_wb.dest_reg_idx     = r.mem_in.dest_reg_idx;
        end
        if (r.mem_in.mem_write_enable && !r.mem_in.no_op && addr < `IO_BASE) begin
            model_mem[addr % `DMEM_DEPTH] = r.mem_in.store_data;
        end
        if (r.keypad_strobe) begin
            model_keypad = r.keypad_data;
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        mem_in         = '0;
        hazard_control = cpu_pkg::HAZD_CTL_NORMAL;
        ignore_no_op   = 1'b0;
        keypad_data    = '0;
        keypad_strobe  = 1'b0;
        switch_map     = '0;
        read_idx_a     = '0;
        read_idx_b     = '0;
        lfsr_state     = 32'h2389;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        model_keypad = '0;
        exp_wb       = '0;                                   // reset value of the stage
        build_table();
        cycle_limit = row_q.size() * 3 + 20;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;                                        // row 0 goes out with the release
        for (int i = 0; i < row_q.size(); i++) begin
            if (i != 0) begin
                @(posedge clk);
                #1;
            end
            apply_row(row_q[i]);
            #1;                                              // read ports settled
            check_value(name_q[i], "wb_out", exp_wb, wb_out);
            check_value(name_q[i], "read_data_a", model_regs[row_q[i].read_idx_a], read_data_a);
            check_value(name_q[i], "read_data_b", model_regs[row_q[i].read_idx_b], read_data_b);
            update_model(row_q[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/data_mem.sv
verilog/input_unit.sv
verilog/mem_wb_reg.sv
verilog/general_reg.sv
verilog/mem_wb_top.sv
verif/mem_wb_tb.sv
